//--- Makefile
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
FAIL_PATTERN ?= TB FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+testbench
src/controlPkg.sv
src/instrDecoder.sv
src/waitTimer.sv
src/controlSequencer.sv
src/controlWordGen.sv
src/controlUnit.sv
testbench/controlUnitTb.sv

//--- src/controlPkg.sv
`default_nettype none

package controlPkg;

    // Instruction field widths
    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;

    // Wide enough for the longest dwell
    localparam int CountWidth = 4;

    // Dwell per state, in clk cycles
    localparam logic [CountWidth-1:0] ResetCycles = 2;
    localparam logic [CountWidth-1:0] FetchCycles = 3;
    localparam logic [CountWidth-1:0] ExecCycles = 2;
    localparam logic [CountWidth-1:0] WritebackCycles = 2;
    localparam logic [CountWidth-1:0] MemReadCycles = 2;
    localparam logic [CountWidth-1:0] TrapCycles = 6;
    localparam logic [CountWidth-1:0] ExceptionCycles = 2;

    typedef enum logic [OpcodeWidth-1:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } Opcode;

    typedef enum logic [FunctWidth-1:0] {
        fnJr   = 6'h08,
        fnMfhi = 6'h10,
        fnMflo = 6'h12,
        fnMult = 6'h18,
        fnDiv  = 6'h1a,
        fnAdd  = 6'h20,
        fnSub  = 6'h22,
        fnAnd  = 6'h24,
        fnSlt  = 6'h2a
    } Funct;

    typedef enum logic [3:0] {
        kindAluR, kindMoveHi, kindMoveLo, kindMult, kindDiv, kindJr,
        kindAddi, kindLoad, kindStore, kindJump, kindJumpLink, kindInvalid
    } InstrKind;

    typedef enum logic [4:0] {
        stReset, stFetch, stPcInc, stDecode, stAluExec, stMoveHiLo,
        stMdExec, stSaveHiLo, stJr, stSavePc, stAddiExec, stSaveRd,
        stSaveRt, stMemCalc, stMemRead, stLoadWrite, stStore, stJump,
        stJumpLink, stInvalidOp, stOverflow, stDivByZero, stException
    } State;

    typedef enum logic [2:0] {aluLoad, aluAdd, aluSub, aluAnd, aluCmp} AluOp;

    typedef enum logic [1:0] {pcAluResult, pcRegister, pcJumpTarget} PcSource;

    typedef enum logic [1:0] {destRt, destRd, destRa, destSp} RegDest;

    typedef enum logic [1:0] {toRegTemp, toRegMemory, toRegStackInit, toRegPcLink} MemToReg;

    typedef enum logic [1:0] {wsAlu, wsHi, wsLo, wsCmp} WriteSrc;

    typedef enum logic [1:0] {excNone, excInvalid, excOverflow, excDivZero} ExcCause;

    typedef struct packed {
        logic aluOverflow;
        logic multOverflow;
        logic divByZero;
    } Flags;

    // Everything the datapath needs for one cycle
    typedef struct packed {
        logic memRead;
        logic memWrite;
        logic iorD;
        logic irWrite;
        logic pcWrite;
        logic regWrite;
        logic aluSrcA;
        logic tempWrite;
        logic hiWrite;
        logic loWrite;
        logic divMult;
        logic epcWrite;
        logic exceptionTaken;
        logic [1:0] aluSrcB;
        PcSource pcSource;
        RegDest regDest;
        MemToReg memToReg;
        AluOp aluOp;
        WriteSrc writeSrc;
        ExcCause excCause;
    } ControlWord;

endpackage

`default_nettype wire

//--- src/controlSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
    input wire clk,
    input wire reset,
    input wire controlPkg::InstrKind kind,
    input wire controlPkg::Flags flags,
    input wire mdAck,
    input wire lastCycle,
    output controlPkg::State state
);
    import controlPkg::*;

    State followState;
    State nextState;

    // Where each state goes once its dwell is over
    always_comb
    begin
        case (state)
            stReset: followState = stFetch;
            stFetch: followState = stPcInc;
            stPcInc: followState = stDecode;
            stDecode:
            begin
                case (kind)
                    kindAluR: followState = stAluExec;
                    kindMoveHi, kindMoveLo: followState = stMoveHiLo;
                    kindMult, kindDiv: followState = stMdExec;
                    kindJr: followState = stJr;
                    kindAddi: followState = stAddiExec;
                    kindLoad, kindStore: followState = stMemCalc;
                    kindJump: followState = stJump;
                    kindJumpLink: followState = stJumpLink;
                    default: followState = stInvalidOp;
                endcase
            end
            stAluExec, stMoveHiLo: followState = stSaveRd;
            stAddiExec: followState = stSaveRt;
            stJr: followState = stSavePc;
            stMemCalc: followState = (kind == kindStore) ? stStore : stMemRead;
            stMemRead: followState = stLoadWrite;
            stInvalidOp, stOverflow, stDivByZero: followState = stException;
            default: followState = stFetch;
        endcase
    end

    always_comb
    begin
        nextState = state;
        case (state)
            // Held here until the multiply/divide unit answers
            stMdExec:
            begin
                if (mdAck)
                begin
                    nextState = stSaveHiLo;
                end
            end
            stSaveHiLo:
            begin
                if (!mdAck)
                begin
                    nextState = stFetch;
                end
            end
            default:
            begin
                if (lastCycle)
                begin
                    nextState = followState;
                end
            end
        endcase

        // Traps win over the normal flow
        if (state == stMdExec && kind == kindDiv && flags.divByZero)
        begin
            nextState = stDivByZero;
        end
        else if ((state == stAluExec || state == stAddiExec || state == stMdExec) &&
                 (flags.aluOverflow || flags.multOverflow))
        begin
            nextState = stOverflow;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= stReset;
        end
        else
        begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

//--- src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input wire clk,
    input wire reset,
    input wire controlPkg::Opcode opcode,
    input wire controlPkg::Funct funct,
    input wire controlPkg::Flags flags,
    input wire mdAck,
    output controlPkg::ControlWord ctrl,
    output logic mdReq
);
    import controlPkg::*;

    InstrKind kind;
    State state;
    logic lastCycle;

    instrDecoder decoder (
        .opcode(opcode),
        .funct(funct),
        .kind(kind)
    );

    waitTimer timer (
        .clk(clk),
        .reset(reset),
        .state(state),
        .lastCycle(lastCycle)
    );

    controlSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .kind(kind),
        .flags(flags),
        .mdAck(mdAck),
        .lastCycle(lastCycle),
        .state(state)
    );

    controlWordGen wordGen (
        .state(state),
        .kind(kind),
        .funct(funct),
        .ctrl(ctrl),
        .mdReq(mdReq)
    );

endmodule

`default_nettype wire

//--- src/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input wire controlPkg::State state,
    input wire controlPkg::InstrKind kind,
    input wire controlPkg::Funct funct,
    output controlPkg::ControlWord ctrl,
    output logic mdReq
);
    import controlPkg::*;

    always_comb
    begin
        ctrl = '0;
        case (state)
            // Stack pointer gets its initial value
            stReset:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest = destSp;
                ctrl.memToReg = toRegStackInit;
            end
            stFetch:
            begin
                ctrl.memRead = 1'b1;
                ctrl.aluSrcB = 2'b01;
                ctrl.aluOp = aluAdd;
            end
            stPcInc:
            begin
                ctrl.aluSrcB = 2'b01;
                ctrl.aluOp = aluAdd;
                ctrl.pcSource = pcAluResult;
                ctrl.pcWrite = 1'b1;
                ctrl.irWrite = 1'b1;
            end
            stAluExec:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.tempWrite = 1'b1;
                case (funct)
                    fnSub: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnSlt:
                    begin
                        ctrl.aluOp = aluCmp;
                        ctrl.writeSrc = wsCmp;
                    end
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            stMoveHiLo:
            begin
                ctrl.tempWrite = 1'b1;
                ctrl.writeSrc = (kind == kindMoveHi) ? wsHi : wsLo;
            end
            // HI and LO stay enabled through the whole handshake
            stMdExec, stSaveHiLo:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.hiWrite = 1'b1;
                ctrl.loWrite = 1'b1;
                ctrl.divMult = (kind == kindMult);
            end
            stJr:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluOp = aluLoad;
                ctrl.pcSource = pcRegister;
                ctrl.pcWrite = 1'b1;
            end
            stSavePc:
            begin
                ctrl.pcSource = pcRegister;
                ctrl.pcWrite = 1'b1;
            end
            stAddiExec, stMemCalc:
            begin
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10;
                ctrl.aluOp = aluAdd;
                ctrl.tempWrite = (state == stAddiExec);
            end
            stSaveRd, stSaveRt:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest = (state == stSaveRd) ? destRd : destRt;
                ctrl.memToReg = toRegTemp;
            end
            // Address stays on the ALU output while memory is accessed
            stMemRead, stStore:
            begin
                ctrl.iorD = 1'b1;
                ctrl.aluSrcA = 1'b1;
                ctrl.aluSrcB = 2'b10;
                ctrl.aluOp = aluAdd;
                ctrl.memRead = (state == stMemRead);
                ctrl.memWrite = (state == stStore);
            end
            stLoadWrite:
            begin
                ctrl.iorD = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDest = destRt;
                ctrl.memToReg = toRegMemory;
            end
            stJump, stJumpLink:
            begin
                ctrl.pcSource = pcJumpTarget;
                ctrl.pcWrite = 1'b1;
                if (state == stJumpLink)
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDest = destRa;
                    ctrl.memToReg = toRegPcLink;
                end
            end
            // PC minus 4 goes to EPC, vector read from memory
            stInvalidOp, stOverflow, stDivByZero:
            begin
                ctrl.iorD = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.aluSrcB = 2'b01;
                ctrl.aluOp = aluSub;
                ctrl.epcWrite = 1'b1;
                case (state)
                    stInvalidOp: ctrl.excCause = excInvalid;
                    stOverflow: ctrl.excCause = excOverflow;
                    default: ctrl.excCause = excDivZero;
                endcase
            end
            stException:
            begin
                ctrl.exceptionTaken = 1'b1;
                ctrl.pcWrite = 1'b1;
            end
            default:
            begin
                ctrl = '0;
            end
        endcase
    end

    assign mdReq = (state == stMdExec);

endmodule

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input wire controlPkg::Opcode opcode,
    input wire controlPkg::Funct funct,
    output controlPkg::InstrKind kind
);
    import controlPkg::*;

    always_comb
    begin
        case (opcode)
            opRType:
            begin
                // R-type is sorted by funct
                case (funct)
                    fnAdd, fnSub, fnAnd, fnSlt: kind = kindAluR;
                    fnMfhi: kind = kindMoveHi;
                    fnMflo: kind = kindMoveLo;
                    fnMult: kind = kindMult;
                    fnDiv: kind = kindDiv;
                    fnJr: kind = kindJr;
                    default: kind = kindInvalid;
                endcase
            end
            opAddi: kind = kindAddi;
            opLw: kind = kindLoad;
            opSw: kind = kindStore;
            opJ: kind = kindJump;
            opJal: kind = kindJumpLink;
            default: kind = kindInvalid;
        endcase
    end

endmodule

`default_nettype wire

//--- src/waitTimer.sv
`timescale 1ns/1ps
`default_nettype none

module waitTimer (
    input wire clk,
    input wire reset,
    input wire controlPkg::State state,
    output logic lastCycle
);
    import controlPkg::*;

    State prevState;
    logic [CountWidth-1:0] count;
    logic [CountWidth-1:0] curCount;
    logic [CountWidth-1:0] dwell;

    // Dwell table where handshake states read as one cycle
    always_comb
    begin
        case (state)
            stReset: dwell = ResetCycles;
            stFetch: dwell = FetchCycles;
            stAluExec, stMoveHiLo, stAddiExec: dwell = ExecCycles;
            stSaveRd, stSaveRt: dwell = WritebackCycles;
            stMemRead, stLoadWrite: dwell = MemReadCycles;
            stInvalidOp, stOverflow, stDivByZero: dwell = TrapCycles;
            stException: dwell = ExceptionCycles;
            default: dwell = 1;
        endcase
    end

    // First cycle of a new state counts as zero
    assign curCount = (state != prevState) ? '0 : count;
    assign lastCycle = (curCount == dwell - 1'b1);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prevState <= stReset;
            count <= '0;
        end
        else
        begin
            prevState <= state;
            count <= curCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One error count per kind of result
int controlErrors = 0;
int mdReqErrors = 0;

// Galois LFSR state for the multiply/divide delays
logic [31:0] lfsrState = 32'h327c_c7be;

// One LFSR step per bit handed out
function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
    begin
        lfsrState = lfsrState ^ 32'h8020_0003;
    end
    return outBit;
endfunction

// Delay of 1 to 8 cycles from three bits
function automatic int randDelay();
    logic [2:0] bits;
    bits[0] = lfsrBit();
    bits[1] = lfsrBit();
    bits[2] = lfsrBit();
    return int'(bits) + 1;
endfunction

// Only the fields set in mask take part in the compare
task automatic checkControl(input ControlWord actual, input ControlWord expected,
                            input ControlWord mask, input string what);
    if ((actual & mask) !== (expected & mask))
    begin
        controlErrors++;
        $display("CHECK FAILED at %0t: %s ctrl %h, expected %h under mask %h",
                 $time, what, actual, expected, mask);
    end
endtask

task automatic checkMdReq(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
        mdReqErrors++;
        $display("CHECK FAILED at %0t: %s mdReq %b, expected %b",
                 $time, what, actual, expected);
    end
endtask

`endif

//--- testbench/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
    import controlPkg::*;

    `include "tbChecks.svh"

    // Expected word of one cycle named after the state behind it
    typedef enum logic [4:0] {
        expReset, expFetch, expPcInc, expDecode, expAluAdd, expAluSub, expAluAnd,
        expAluCmp, expMoveHi, expMoveLo, expAddi, expSaveRd, expSaveRt, expMemCalc,
        expMemRead, expLoadWrite, expStore, expJump, expJumpLink, expJr, expSavePc,
        expMdMult, expMdDiv, expSaveHiLo, expTrapInvalid, expTrapOverflow,
        expTrapDivZero, expException
    } ExpStep;

    // Dwell of zero marks a handshake phase
    typedef struct packed {
        ExpStep step;
        logic [3:0] dwell;
    } Segment;

    typedef struct packed {
        Opcode opcode;
        Funct funct;
        Flags inject;
        logic [3:0] injCycle;
        logic [1:0] segCount;
        Segment [2:0] seg;
    } TestRow;

    logic clk = 1'b0;
    logic reset;
    Opcode opcode;
    Funct funct;
    Flags flags;
    logic mdAck = 1'b0;
    ControlWord ctrl;
    logic mdReq;

    TestRow rows[$];
    int cycleCount = 0;
    int cycleLimit = 0;
    int mdPhase = 0;
    int mdDelay = 0;

    controlUnit UUT (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .flags(flags),
        .mdAck(mdAck),
        .ctrl(ctrl),
        .mdReq(mdReq)
    );

    always #4 clk = ~clk;

    function automatic Segment phase(input ExpStep step, input logic [3:0] dwell);
        Segment s;
        s.step = step;
        s.dwell = dwell;
        return s;
    endfunction

    task automatic addRow(input Opcode op, input Funct fn, input Flags inject,
                          input logic [3:0] injCycle, input logic [1:0] segCount,
                          input Segment s0, input Segment s1, input Segment s2);
        TestRow row;
        row.opcode = op;
        row.funct = fn;
        row.inject = inject;
        row.injCycle = injCycle;
        row.segCount = segCount;
        row.seg[0] = s0;
        row.seg[1] = s1;
        row.seg[2] = s2;
        rows.push_back(row);
    endtask

    // Post-decode phases of every instruction under test
    task automatic buildTable();
        Flags ovf;
        Flags mulOvf;
        Flags divZero;
        ovf = '0;
        ovf.aluOverflow = 1'b1;
        mulOvf = '0;
        mulOvf.multOverflow = 1'b1;
        divZero = '0;
        divZero.divByZero = 1'b1;
        addRow(opRType, fnAdd, '0, 4'd0, 2'd2, phase(expAluAdd, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opRType, fnSub, '0, 4'd0, 2'd2, phase(expAluSub, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opRType, fnAnd, '0, 4'd0, 2'd2, phase(expAluAnd, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opRType, fnSlt, '0, 4'd0, 2'd2, phase(expAluCmp, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opRType, fnMfhi, '0, 4'd0, 2'd2, phase(expMoveHi, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opRType, fnMflo, '0, 4'd0, 2'd2, phase(expMoveLo, ExecCycles),
               phase(expSaveRd, WritebackCycles), '0);
        addRow(opAddi, fnAdd, '0, 4'd0, 2'd2, phase(expAddi, ExecCycles),
               phase(expSaveRt, WritebackCycles), '0);
        addRow(opLw, fnAdd, '0, 4'd0, 2'd3, phase(expMemCalc, 4'd1),
               phase(expMemRead, MemReadCycles), phase(expLoadWrite, MemReadCycles));
        addRow(opSw, fnAdd, '0, 4'd0, 2'd2, phase(expMemCalc, 4'd1),
               phase(expStore, 4'd1), '0);
        addRow(opJ, fnAdd, '0, 4'd0, 2'd1, phase(expJump, 4'd1), '0, '0);
        addRow(opJal, fnAdd, '0, 4'd0, 2'd1, phase(expJumpLink, 4'd1), '0, '0);
        addRow(opRType, fnJr, '0, 4'd0, 2'd2, phase(expJr, 4'd1),
               phase(expSavePc, 4'd1), '0);
        addRow(opRType, fnMult, '0, 4'd0, 2'd2, phase(expMdMult, 4'd0),
               phase(expSaveHiLo, 4'd0), '0);
        addRow(opRType, fnDiv, '0, 4'd0, 2'd2, phase(expMdDiv, 4'd0),
               phase(expSaveHiLo, 4'd0), '0);
        addRow(opRType, fnMult, '0, 4'd0, 2'd2, phase(expMdMult, 4'd0),
               phase(expSaveHiLo, 4'd0), '0);
        addRow(opRType, fnDiv, '0, 4'd0, 2'd2, phase(expMdDiv, 4'd0),
               phase(expSaveHiLo, 4'd0), '0);
        // Traps
        addRow(Opcode'(6'h3f), fnAdd, '0, 4'd0, 2'd2, phase(expTrapInvalid, TrapCycles),
               phase(expException, ExceptionCycles), '0);
        addRow(opRType, Funct'(6'h3f), '0, 4'd0, 2'd2, phase(expTrapInvalid, TrapCycles),
               phase(expException, ExceptionCycles), '0);
        addRow(opRType, fnAdd, ovf, 4'd1, 2'd3, phase(expAluAdd, ExecCycles),
               phase(expTrapOverflow, TrapCycles), phase(expException, ExceptionCycles));
        addRow(opAddi, fnAdd, ovf, 4'd0, 2'd3, phase(expAddi, 4'd1),
               phase(expTrapOverflow, TrapCycles), phase(expException, ExceptionCycles));
        addRow(opRType, fnMult, mulOvf, 4'd0, 2'd3, phase(expMdMult, 4'd1),
               phase(expTrapOverflow, TrapCycles), phase(expException, ExceptionCycles));
        addRow(opRType, fnDiv, divZero, 4'd0, 2'd3, phase(expMdDiv, 4'd1),
               phase(expTrapDivZero, TrapCycles), phase(expException, ExceptionCycles));
    endtask

    // Twice the table length, slack for handshakes, plus a margin
    function automatic int computeLimit();
        int total;
        int mdRows;
        total = 8 + int'(ResetCycles);
        mdRows = 0;
        foreach (rows[i])
        begin
            total += int'(FetchCycles) + 2;
            for (logic [1:0] s = 0; s < rows[i].segCount; s++)
            begin
                total += int'(rows[i].seg[s].dwell);
            end
            if (rows[i].seg[0].step == expMdMult || rows[i].seg[0].step == expMdDiv)
            begin
                mdRows++;
            end
        end
        return 2 * total + 20 * mdRows + 100;
    endfunction

    // Expected value and compare mask of one cycle
    function automatic void expectWord(input ExpStep step, output ControlWord w,
                                       output ControlWord m);
        w = '0;
        m = '0;
        m.memRead = 1'b1;
        m.memWrite = 1'b1;
        m.irWrite = 1'b1;
        m.pcWrite = 1'b1;
        m.regWrite = 1'b1;
        m.hiWrite = 1'b1;
        m.loWrite = 1'b1;
        m.epcWrite = 1'b1;
        m.exceptionTaken = 1'b1;
        m.excCause = ExcCause'(2'b11);
        case (step)
            // Stack pointer setup and every other control inactive
            expReset:
            begin
                w.regWrite = 1'b1;
                w.regDest = destSp;
                w.memToReg = toRegStackInit;
                m = '1;
            end
            expFetch: w.memRead = 1'b1;
            expPcInc:
            begin
                w.pcWrite = 1'b1;
                w.irWrite = 1'b1;
                w.pcSource = pcAluResult;
                m.pcSource = PcSource'(2'b11);
            end
            expAluAdd, expAluSub, expAluAnd, expAluCmp, expAddi:
            begin
                case (step)
                    expAluSub: w.aluOp = aluSub;
                    expAluAnd: w.aluOp = aluAnd;
                    expAluCmp: w.aluOp = aluCmp;
                    default: w.aluOp = aluAdd;
                endcase
                w.writeSrc = (step == expAluCmp) ? wsCmp : wsAlu;
                m.aluOp = AluOp'(3'b111);
                m.writeSrc = WriteSrc'(2'b11);
            end
            expMoveHi, expMoveLo:
            begin
                w.writeSrc = (step == expMoveHi) ? wsHi : wsLo;
                m.writeSrc = WriteSrc'(2'b11);
            end
            expSaveRd, expSaveRt, expLoadWrite:
            begin
                w.regWrite = 1'b1;
                w.regDest = (step == expSaveRd) ? destRd : destRt;
                w.memToReg = (step == expLoadWrite) ? toRegMemory : toRegTemp;
                m.regDest = RegDest'(2'b11);
                m.memToReg = MemToReg'(2'b11);
            end
            expMemRead: w.memRead = 1'b1;
            expStore: w.memWrite = 1'b1;
            expJump, expJumpLink, expJr, expSavePc:
            begin
                w.pcWrite = 1'b1;
                w.pcSource = (step == expJump || step == expJumpLink) ? pcJumpTarget
                                                                      : pcRegister;
                m.pcSource = PcSource'(2'b11);
                if (step == expJumpLink)
                begin
                    w.regWrite = 1'b1;
                    w.regDest = destRa;
                    w.memToReg = toRegPcLink;
                    m.regDest = RegDest'(2'b11);
                    m.memToReg = MemToReg'(2'b11);
                end
            end
            expMdMult, expMdDiv, expSaveHiLo:
            begin
                w.hiWrite = 1'b1;
                w.loWrite = 1'b1;
                w.divMult = (step == expMdMult);
                m.divMult = (step != expSaveHiLo);
            end
            expTrapInvalid, expTrapOverflow, expTrapDivZero:
            begin
                // The trap may read the vector so memRead is left free
                m.memRead = 1'b0;
                w.epcWrite = 1'b1;
                case (step)
                    expTrapInvalid: w.excCause = excInvalid;
                    expTrapOverflow: w.excCause = excOverflow;
                    default: w.excCause = excDivZero;
                endcase
            end
            expException:
            begin
                w.exceptionTaken = 1'b1;
                w.pcWrite = 1'b1;
            end
            default: w = '0;
        endcase
    endfunction

    task automatic checkStep(input ExpStep step, input string what);
        ControlWord w;
        ControlWord m;
        string label;
        label = $sformatf("%s %s", what, step.name());
        expectWord(step, w, m);
        checkControl(ctrl, w, m, label);
        checkMdReq(mdReq, step == expMdMult || step == expMdDiv, label);
    endtask

    // Drive on the rising edge, check on the falling edge
    task automatic runCycle(input TestRow row, input ExpStep step, input Flags drive,
                            input string what);
        @(posedge clk);
        opcode <= row.opcode;
        funct <= row.funct;
        flags <= drive;
        @(negedge clk);
        checkStep(step, what);
    endtask

    // Lasts until mdAck reaches the level the sequencer waits for
    task automatic runHandshake(input TestRow row, input ExpStep step, input string what);
        logic done;
        done = 1'b0;
        while (!done)
        begin
            runCycle(row, step, '0, what);
            done = (step == expSaveHiLo) ? !mdAck : mdAck;
        end
    endtask

    task automatic runRow(input int idx);
        TestRow row;
        string name;
        int execCycle;
        Flags drive;
        row = rows[idx];
        name = $sformatf("row %0d", idx);
        for (int k = 0; k < int'(FetchCycles); k++)
        begin
            runCycle(row, expFetch, '0, name);
        end
        runCycle(row, expPcInc, '0, name);
        runCycle(row, expDecode, '0, name);
        execCycle = 0;
        for (logic [1:0] s = 0; s < row.segCount; s++)
        begin
            if (row.seg[s].dwell == 4'd0)
            begin
                runHandshake(row, row.seg[s].step, name);
            end
            else
            begin
                for (int k = 0; k < int'(row.seg[s].dwell); k++)
                begin
                    drive = (execCycle == int'(row.injCycle)) ? row.inject : '0;
                    runCycle(row, row.seg[s].step, drive, name);
                    execCycle++;
                end
            end
        end
    endtask

    // Multiply/divide unit model that abandons a request dropped early
    always @(posedge clk)
    begin
        if (reset)
        begin
            mdAck <= 1'b0;
            mdPhase <= 0;
        end
        else
        begin
            case (mdPhase)
                0:
                begin
                    if (mdReq)
                    begin
                        mdDelay <= randDelay();
                        mdPhase <= 1;
                    end
                end
                1:
                begin
                    if (!mdReq)
                    begin
                        mdPhase <= 0;
                    end
                    else if (mdDelay <= 1)
                    begin
                        mdAck <= 1'b1;
                        mdDelay <= randDelay();
                        mdPhase <= 2;
                    end
                    else
                    begin
                        mdDelay <= mdDelay - 1;
                    end
                end
                default:
                begin
                    // Ack falls a while after the request is gone
                    if (!mdReq)
                    begin
                        if (mdDelay <= 1)
                        begin
                            mdAck <= 1'b0;
                            mdPhase <= 0;
                        end
                        else
                        begin
                            mdDelay <= mdDelay - 1;
                        end
                    end
                end
            endcase
        end
    end

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            $display("Run timed out after %0d cycles without reaching the end of the table",
                     cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b1;
        opcode = opRType;
        funct = fnAdd;
        flags = '0;
        buildTable();
        cycleLimit = computeLimit();

        // Eight cycles in reset, then the reset dwell
        for (int k = 0; k < 7 + int'(ResetCycles); k++)
        begin
            @(posedge clk);
            if (k == 7)
            begin
                reset <= 1'b0;
            end
            @(negedge clk);
            checkStep(expReset, "reset");
        end

        foreach (rows[i])
        begin
            runRow(i);
        end

        $display("Checks done: %0d control errors, %0d mdReq errors",
                 controlErrors, mdReqErrors);
        if (controlErrors == 0 && mdReqErrors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
